// ==== common/calc_pkg.sv ====
package calc_pkg;

  // Number of matrix slots in the store
  localparam int NUM_MATS = 4;

  // One matrix element, arithmetic wraps modulo 256
  typedef logic [7:0] elem_t;

  // 2x2 matrix, row-major
  // Element 0 (row 0, col 0) sits in the low byte
  // Layout {m11, m10, m01, m00}
  typedef logic [31:0] mat_t;

  // Matrix ID as typed by the user, digits 0..9
  // Only IDs below NUM_MATS exist in the store
  typedef logic [3:0] mat_id_t;

  typedef enum logic [2:0] {
    OP_NONE,        // Nothing selected
    OP_TRANSPOSE,   // Unary
    OP_ADD,         // Binary, element-wise
    OP_SCALAR_MUL,  // Unary plus switch scalar
    OP_MAT_MUL,     // Binary, row x column
    OP_CONV         // Reserved, ALU flags it as an error
  } op_code_t;

  // Calculator controller states
  typedef enum logic [3:0] {
    IDLE,
    SELECT_OP,       // Wait for switch selection and confirm
    SELECT_A,        // Wait for first ID digit
    SELECT_B,        // Wait for second ID digit
    CONFIRM_SCALAR,  // Wait for scalar confirm
    EXEC_ALU,        // Fire ALU start
    WAIT_ALU,
    ERROR_HOLD,      // Error LED countdown
    EXEC_PRINT,      // Fire printer start
    WAIT_PRINT,
    DONE_WAIT        // Result shown, wait for user
  } ctrl_state_t;

endpackage

// ==== common/alu_if.sv ====
`timescale 1ns/100ps

interface alu_if;

  logic               start;  // One-cycle pulse, ALU must be idle
  calc_pkg::op_code_t op;     // Held from start until done or err
  calc_pkg::mat_id_t  id_a;
  calc_pkg::mat_id_t  id_b;   // Don't care for unary ops
  logic               done;   // Result valid, held until next start
  logic               err;    // Bad ID or unsupported op

  // Controller side
  modport ctrl (
    output start, op, id_a, id_b,
    input  done, err
  );

  // ALU side
  modport alu (
    input  start, op, id_a, id_b,
    output done, err
  );

endinterface

// ==== hdl/calc_ctrl.sv ====
`timescale 1ns/100ps

module calc_ctrl #(
  parameter int ERR_HOLD_CYCLES = 16  // Error LED hold time in cycles
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start_en,       // Main menu hands over control
  input  logic [7:0] sw_mode_sel,    // Op switches, bit 7 has priority
  input  logic       btn_confirm,
  input  logic       btn_esc,
  input  logic [7:0] rx_data,        // ASCII byte from receiver
  input  logic       rx_done,        // rx_data valid strobe
  input  logic       print_done,
  output logic       print_start,
  output logic       calc_sys_done,  // Back to main menu
  output logic       calc_err,       // Drives error LED
  alu_if.ctrl        alu
);

  // Counter must reach ERR_HOLD_CYCLES
  localparam int CNT_W = (ERR_HOLD_CYCLES > 1) ? $clog2(ERR_HOLD_CYCLES + 1) : 1;

  calc_pkg::ctrl_state_t state;
  calc_pkg::op_code_t    op_q;
  calc_pkg::op_code_t    sel_op;
  calc_pkg::mat_id_t     id_a_q;
  calc_pkg::mat_id_t     id_b_q;
  calc_pkg::mat_id_t     digit_id;
  logic [CNT_W-1:0]      err_cnt;
  logic                  confirm_q;
  logic                  esc_q;
  logic                  confirm_rise;
  logic                  esc_rise;
  logic                  digit_ok;

  // Rising edges of the buttons
  assign confirm_rise = btn_confirm & ~confirm_q;
  assign esc_rise     = btn_esc & ~esc_q;

  // ASCII '0'..'9' only, anything else is dropped
  assign digit_ok = rx_done && (rx_data[7:4] == 4'h3) && (rx_data[3:0] <= 4'd9);
  assign digit_id = rx_data[3:0];  // Low nibble is the digit value

  assign alu.op   = op_q;
  assign alu.id_a = id_a_q;
  assign alu.id_b = id_b_q;

  // Switch priority: conv, mat mul, scalar mul, add, transpose
  always_comb begin
    casez (sw_mode_sel[7:3])
      5'b1????: sel_op = calc_pkg::OP_CONV;
      5'b01???: sel_op = calc_pkg::OP_MAT_MUL;
      5'b001??: sel_op = calc_pkg::OP_SCALAR_MUL;
      5'b0001?: sel_op = calc_pkg::OP_ADD;
      5'b00001: sel_op = calc_pkg::OP_TRANSPOSE;
      default:  sel_op = calc_pkg::OP_NONE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= calc_pkg::IDLE;
      op_q          <= calc_pkg::OP_NONE;
      id_a_q        <= '0;
      id_b_q        <= '0;
      err_cnt       <= '0;
      confirm_q     <= 1'b0;
      esc_q         <= 1'b0;
      alu.start     <= 1'b0;
      print_start   <= 1'b0;
      calc_sys_done <= 1'b0;
      calc_err      <= 1'b0;
    end else begin
      confirm_q     <= btn_confirm;
      esc_q         <= btn_esc;
      alu.start     <= 1'b0;  // Pulses default low
      print_start   <= 1'b0;
      calc_sys_done <= 1'b0;

      case (state)
        calc_pkg::IDLE: begin
          calc_err <= 1'b0;
          err_cnt  <= '0;
          if (start_en) state <= calc_pkg::SELECT_OP;
        end
        calc_pkg::SELECT_OP: begin
          if (esc_rise) begin
            calc_sys_done <= 1'b1;  // Leave calculator mode
            state         <= calc_pkg::IDLE;
          end else if (confirm_rise && sel_op != calc_pkg::OP_NONE) begin
            op_q  <= sel_op;
            state <= calc_pkg::SELECT_A;
          end
        end
        calc_pkg::SELECT_A: begin
          if (esc_rise) begin
            state <= calc_pkg::SELECT_OP;
          end else if (digit_ok) begin
            id_a_q <= digit_id;
            // Binary ops need a second ID
            if (op_q == calc_pkg::OP_ADD || op_q == calc_pkg::OP_MAT_MUL)
              state <= calc_pkg::SELECT_B;
            else if (op_q == calc_pkg::OP_SCALAR_MUL)
              state <= calc_pkg::CONFIRM_SCALAR;
            else
              state <= calc_pkg::EXEC_ALU;  // Transpose, conv
          end
        end
        calc_pkg::SELECT_B: begin
          if (esc_rise) begin
            state <= calc_pkg::SELECT_A;
          end else if (digit_ok) begin
            id_b_q <= digit_id;
            state  <= calc_pkg::EXEC_ALU;
          end
        end
        calc_pkg::CONFIRM_SCALAR: begin
          if (esc_rise) state <= calc_pkg::SELECT_A;
          else if (confirm_rise) state <= calc_pkg::EXEC_ALU;  // ALU samples scalar on start
        end
        calc_pkg::EXEC_ALU: begin
          alu.start <= 1'b1;
          state     <= calc_pkg::WAIT_ALU;
        end
        calc_pkg::WAIT_ALU: begin
          if (alu.err) begin
            calc_err <= 1'b1;  // LED on with entry into hold
            err_cnt  <= '0;
            state    <= calc_pkg::ERROR_HOLD;
          end else if (alu.done) begin
            state <= calc_pkg::EXEC_PRINT;
          end
        end
        calc_pkg::ERROR_HOLD: begin
          if (esc_rise || err_cnt == CNT_W'(ERR_HOLD_CYCLES)) begin
            calc_err <= 1'b0;  // Manual cancel or timeout
            state    <= calc_pkg::SELECT_OP;
          end else begin
            err_cnt <= err_cnt + 1'b1;
          end
        end
        calc_pkg::EXEC_PRINT: begin
          print_start <= 1'b1;
          state       <= calc_pkg::WAIT_PRINT;
        end
        calc_pkg::WAIT_PRINT: begin
          if (print_done) state <= calc_pkg::DONE_WAIT;
        end
        calc_pkg::DONE_WAIT: begin
          // Either button starts a new operation
          if (esc_rise || confirm_rise) state <= calc_pkg::SELECT_OP;
        end
        default: state <= calc_pkg::IDLE;
      endcase
    end
  end

endmodule

// ==== hdl/mat_store.sv ====
`timescale 1ns/100ps

module mat_store (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load_en,    // Write whole matrix this cycle
  input  calc_pkg::mat_id_t load_id,
  input  calc_pkg::mat_t    load_data,
  input  calc_pkg::mat_id_t rd_id,      // From ALU
  output calc_pkg::mat_t    rd_data     // One cycle after rd_id
);

  // Slot select width, upper ID bits ignored here
  localparam int IDX_W = $clog2(calc_pkg::NUM_MATS);

  calc_pkg::mat_t mats [calc_pkg::NUM_MATS];

  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;

  assign wr_idx = load_id[IDX_W-1:0];
  assign rd_idx = rd_id[IDX_W-1:0];  // ALU has already rejected bad IDs

  // Matrix slots, cleared on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < calc_pkg::NUM_MATS; i++) begin
        mats[i] <= '0;
      end
    end else if (load_en) begin
      mats[wr_idx] <= load_data;
    end
  end

  // Registered read port
  always_ff @(posedge clk) begin
    rd_data <= mats[rd_idx];
  end

endmodule

// ==== alu/mat_alu.sv ====
`timescale 1ns/100ps

module mat_alu (
  input  logic              clk,
  input  logic              rst_n,
  input  calc_pkg::elem_t   scalar,   // Switch value, sampled on start
  input  calc_pkg::mat_t    rd_data,  // Store read data
  output calc_pkg::mat_id_t rd_id,    // Store read address
  output calc_pkg::mat_t    result,   // Held until next start
  alu_if.alu                alu
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_FETCH_A,  // rd_id = A
    S_GET_A,    // A on rd_data, rd_id = B
    S_GET_B,    // B on rd_data
    S_CALC      // Binary ops only
  } alu_state_t;

  alu_state_t         state;
  calc_pkg::op_code_t op_q;
  calc_pkg::mat_id_t  id_a_q;
  calc_pkg::mat_id_t  id_b_q;
  calc_pkg::elem_t    scalar_q;
  calc_pkg::mat_t     a_q;
  calc_pkg::mat_t     b_q;
  logic               binary_op;
  logic               bad_req;

  // All element arithmetic wraps to 8 bits
  function automatic calc_pkg::mat_t mat_compute(input calc_pkg::op_code_t op,
                                                 input calc_pkg::mat_t a,
                                                 input calc_pkg::mat_t b,
                                                 input calc_pkg::elem_t s);
    calc_pkg::mat_t r;
    r = '0;
    case (op)
      calc_pkg::OP_TRANSPOSE: r = {a[31:24], a[15:8], a[23:16], a[7:0]};  // Swap m01, m10
      calc_pkg::OP_ADD: begin
        for (int i = 0; i < 4; i++) r[8*i +: 8] = a[8*i +: 8] + b[8*i +: 8];
      end
      calc_pkg::OP_SCALAR_MUL: begin
        for (int i = 0; i < 4; i++) r[8*i +: 8] = a[8*i +: 8] * s;
      end
      calc_pkg::OP_MAT_MUL: begin
        // c[row][col] = a[row][0]*b[0][col] + a[row][1]*b[1][col]
        for (int row = 0; row < 2; row++) begin
          for (int col = 0; col < 2; col++) begin
            r[8*(2*row+col) +: 8] = a[16*row +: 8] * b[8*col +: 8]
                                  + a[16*row+8 +: 8] * b[16+8*col +: 8];
          end
        end
      end
      default: r = '0;
    endcase
    return r;
  endfunction

  assign binary_op = (alu.op == calc_pkg::OP_ADD) || (alu.op == calc_pkg::OP_MAT_MUL);

  // Range and op check on start
  assign bad_req = (alu.op == calc_pkg::OP_NONE) || (alu.op == calc_pkg::OP_CONV)
                 || (alu.id_a >= calc_pkg::mat_id_t'(calc_pkg::NUM_MATS))
                 || (binary_op && alu.id_b >= calc_pkg::mat_id_t'(calc_pkg::NUM_MATS));

  assign rd_id = (state == S_GET_A) ? id_b_q : id_a_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= S_IDLE;
      alu.done <= 1'b0;
      alu.err  <= 1'b0;
    end else begin
      alu.done <= 1'b0;
      alu.err  <= 1'b0;
      case (state)
        S_IDLE: begin
          if (alu.start && bad_req) alu.err <= 1'b1;  // Err one cycle after start
          else if (alu.start) state <= S_FETCH_A;
        end
        S_FETCH_A: state <= S_GET_A;
        S_GET_A: begin
          if (op_q == calc_pkg::OP_ADD || op_q == calc_pkg::OP_MAT_MUL) begin
            state <= S_GET_B;
          end else begin
            alu.done <= 1'b1;  // Unary result straight from rd_data
            state    <= S_IDLE;
          end
        end
        S_GET_B: state <= S_CALC;
        S_CALC: begin
          alu.done <= 1'b1;
          state    <= S_IDLE;
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Operand capture and result register
  always_ff @(posedge clk) begin
    if (state == S_IDLE && alu.start) begin
      op_q     <= alu.op;
      id_a_q   <= alu.id_a;
      id_b_q   <= alu.id_b;
      scalar_q <= scalar;
    end
    if (state == S_GET_A) a_q <= rd_data;
    if (state == S_GET_B) b_q <= rd_data;
    if (state == S_GET_A && !(op_q == calc_pkg::OP_ADD || op_q == calc_pkg::OP_MAT_MUL))
      result <= mat_compute(op_q, rd_data, rd_data, scalar_q);
    if (state == S_CALC) result <= mat_compute(op_q, a_q, b_q, scalar_q);
  end

endmodule

// ==== hdl/result_printer.sv ====
`timescale 1ns/100ps

module result_printer (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            print_start,  // Latch result and begin
  input  calc_pkg::mat_t  result,       // ALU result matrix
  input  logic            tx_ready,
  output calc_pkg::elem_t tx_data,
  output logic            tx_valid,
  output logic            print_done    // One cycle after last transfer
);

  calc_pkg::mat_t mat_q;  // Snapshot of the result
  logic [1:0]     idx;    // Element index, row-major
  logic           xfer;

  assign xfer    = tx_valid && tx_ready;
  assign tx_data = mat_q[8*idx +: 8];  // Stable while idx holds

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx        <= '0;
      tx_valid   <= 1'b0;
      print_done <= 1'b0;
    end else begin
      print_done <= 1'b0;
      if (!tx_valid && print_start) begin
        idx      <= '0;
        tx_valid <= 1'b1;
      end else if (xfer) begin
        if (idx == 2'd3) begin
          tx_valid   <= 1'b0;  // Last byte gone, back to idle
          print_done <= 1'b1;
        end else begin
          idx <= idx + 2'd1;
        end
      end
    end
  end

  // Snapshot only when idle
  always_ff @(posedge clk) begin
    if (!tx_valid && print_start) mat_q <= result;
  end

endmodule

// ==== hdl/matrix_calc_top.sv ====
`timescale 1ns/100ps

module matrix_calc_top #(
  parameter int ERR_HOLD_CYCLES = 16
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start_en,
  input  logic [7:0]        sw_mode_sel,
  input  calc_pkg::elem_t   sw_scalar,
  input  logic              btn_confirm,
  input  logic              btn_esc,
  input  logic [7:0]        rx_data,
  input  logic              rx_done,
  input  logic              load_en,    // Matrix preload
  input  calc_pkg::mat_id_t load_id,
  input  calc_pkg::mat_t    load_data,
  input  logic              tx_ready,
  output calc_pkg::elem_t   tx_data,
  output logic              tx_valid,
  output logic              calc_sys_done,
  output logic              calc_err
);

  calc_pkg::mat_id_t rd_id;
  calc_pkg::mat_t    rd_data;
  calc_pkg::mat_t    alu_result;
  logic              print_start;
  logic              print_done;

  alu_if alu_bus ();  // Controller to ALU

  calc_ctrl #(
    .ERR_HOLD_CYCLES(ERR_HOLD_CYCLES)
  ) calc_ctrl_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .start_en      (start_en),
    .sw_mode_sel   (sw_mode_sel),
    .btn_confirm   (btn_confirm),
    .btn_esc       (btn_esc),
    .rx_data       (rx_data),
    .rx_done       (rx_done),
    .print_done    (print_done),
    .print_start   (print_start),
    .calc_sys_done (calc_sys_done),
    .calc_err      (calc_err),
    .alu           (alu_bus.ctrl)
  );

  mat_store mat_store_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .load_id   (load_id),
    .load_data (load_data),
    .rd_id     (rd_id),
    .rd_data   (rd_data)
  );

  mat_alu mat_alu_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .scalar  (sw_scalar),
    .rd_data (rd_data),
    .rd_id   (rd_id),
    .result  (alu_result),
    .alu     (alu_bus.alu)
  );

  result_printer result_printer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .print_start (print_start),
    .result      (alu_result),
    .tx_ready    (tx_ready),
    .tx_data     (tx_data),
    .tx_valid    (tx_valid),
    .print_done  (print_done)
  );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset held for a fixed number of cycles, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== test/calc_checker.sv ====
`timescale 1ns/100ps

module calc_checker (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  alu_start,
  input logic                  calc_err,
  input logic                  tx_valid,
  input logic                  tx_ready,
  input calc_pkg::elem_t       tx_data,
  input calc_pkg::ctrl_state_t state    // Controller FSM state
);

  int fail_cnt = 0;  // Read by the testbench at the end

  // ALU start is a one-cycle pulse
  start_pulse: assert property (@(posedge clk) disable iff (!rst_n) alu_start |=> !alu_start)
    else begin
      fail_cnt++;
      $error("ALU start stayed high for more than one cycle");
    end

  // Stalled byte must not change
  tx_hold: assert property (@(posedge clk) disable iff (!rst_n)
                            tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else begin
      fail_cnt++;
      $error("tx_data or tx_valid changed under back-pressure");
    end

  // Error LED only during the hold state
  err_state: assert property (@(posedge clk) disable iff (!rst_n)
                              calc_err |-> state == calc_pkg::ERROR_HOLD)
    else begin
      fail_cnt++;
      $error("calc_err high outside ERROR_HOLD");
    end

endmodule

bind matrix_calc_top calc_checker calc_checker_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .alu_start (alu_bus.start),
  .calc_err  (calc_err),
  .tx_valid  (tx_valid),
  .tx_ready  (tx_ready),
  .tx_data   (tx_data),
  .state     (calc_ctrl_inst.state)
);

// ==== test/tb_matrix_calc.sv ====
`timescale 1ns/100ps

module tb_matrix_calc;

  localparam int         ERR_HOLD_CYCLES = 16;
  localparam int         NUM_ROWS        = 7;
  localparam logic [1:0] MODE_PLAIN      = 2'd0;
  localparam logic [1:0] MODE_ESC        = 2'd1;  // Leave error hold by escape
  localparam logic [1:0] MODE_PROBE      = 2'd2;  // Null confirm and junk bytes first

  // One operation of the stimulus table
  typedef struct packed {
    logic [7:0]      sw;      // Mode switches
    logic [7:0]      dig_a;   // ASCII digit for A
    logic [7:0]      dig_b;   // ASCII digit for B on binary ops
    calc_pkg::elem_t scalar;
    logic            is_err;  // ALU must reject this one
    logic [1:0]      mode;
  } row_t;

  logic              clk;
  logic              rst_n;
  logic              start_en;
  logic [7:0]        sw_mode_sel;
  calc_pkg::elem_t   sw_scalar;
  logic              btn_confirm;
  logic              btn_esc;
  logic [7:0]        rx_data;
  logic              rx_done;
  logic              load_en;
  calc_pkg::mat_id_t load_id;
  calc_pkg::mat_t    load_data;
  logic              tx_ready;
  calc_pkg::elem_t   tx_data;
  logic              tx_valid;
  logic              calc_sys_done;
  logic              calc_err;

  row_t            rows [NUM_ROWS];
  calc_pkg::mat_t  mats [calc_pkg::NUM_MATS];  // Copy of loaded store
  calc_pkg::elem_t rx_bytes [$];               // Bytes seen on tx
  integer          seed = 32'h85d5;
  int              sys_done_cnt = 0;
  logic            loaded = 1'b0;
  logic            in_done_wait = 1'b0;        // Result shown and waiting for a press

  tb_clock #(.PERIOD_NS(4), .RESET_CYCLES(10)) tb_clock_inst (.clk(clk), .rst_n(rst_n));

  matrix_calc_top #(
    .ERR_HOLD_CYCLES(ERR_HOLD_CYCLES)
  ) matrix_calc_top_inst (
    .clk(clk), .rst_n(rst_n), .start_en(start_en), .sw_mode_sel(sw_mode_sel),
    .sw_scalar(sw_scalar), .btn_confirm(btn_confirm), .btn_esc(btn_esc),
    .rx_data(rx_data), .rx_done(rx_done), .load_en(load_en), .load_id(load_id),
    .load_data(load_data), .tx_ready(tx_ready), .tx_data(tx_data), .tx_valid(tx_valid),
    .calc_sys_done(calc_sys_done), .calc_err(calc_err)
  );

  function automatic calc_pkg::elem_t get_el(input calc_pkg::mat_t m, input int r, input int c);
    return m[8*(2*r+c) +: 8];  // Row-major with m00 in the low byte
  endfunction

  // Expected result with 8-bit wrap everywhere
  function automatic calc_pkg::mat_t ref_result(input calc_pkg::op_code_t op,
                                                input calc_pkg::mat_t a,
                                                input calc_pkg::mat_t b,
                                                input calc_pkg::elem_t s);
    calc_pkg::mat_t  r;
    calc_pkg::elem_t e;
    r = '0;
    for (int i = 0; i < 2; i++) begin
      for (int j = 0; j < 2; j++) begin
        case (op)
          calc_pkg::OP_TRANSPOSE:  e = get_el(a, j, i);
          calc_pkg::OP_ADD:        e = get_el(a, i, j) + get_el(b, i, j);
          calc_pkg::OP_SCALAR_MUL: e = get_el(a, i, j) * s;
          calc_pkg::OP_MAT_MUL:    e = get_el(a, i, 0) * get_el(b, 0, j)
                                     + get_el(a, i, 1) * get_el(b, 1, j);
          default:                 e = '0;
        endcase
        r[8*(2*i+j) +: 8] = e;
      end
    end
    return r;
  endfunction

  // Highest set switch wins from bit 7 down
  function automatic calc_pkg::op_code_t op_from_sw(input logic [7:0] sw);
    if (sw[7]) return calc_pkg::OP_CONV;
    else if (sw[6]) return calc_pkg::OP_MAT_MUL;
    else if (sw[5]) return calc_pkg::OP_SCALAR_MUL;
    else if (sw[4]) return calc_pkg::OP_ADD;
    else if (sw[3]) return calc_pkg::OP_TRANSPOSE;
    else return calc_pkg::OP_NONE;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic set_switches(input logic [7:0] sw, input calc_pkg::elem_t s);
    @(negedge clk);
    sw_mode_sel = sw;
    sw_scalar   = s;
  endtask

  // One-cycle press followed by a released cycle
  task automatic press_button(input logic esc);
    @(negedge clk);
    if (esc) btn_esc = 1'b1;
    else btn_confirm = 1'b1;
    @(negedge clk);
    btn_esc     = 1'b0;
    btn_confirm = 1'b0;
  endtask

  task automatic send_byte(input logic [7:0] b);
    @(negedge clk);
    rx_data = b;
    rx_done = 1'b1;  // Receiver strobe
    @(negedge clk);
    rx_done = 1'b0;
  endtask

  task automatic run_row(input int n);
    calc_pkg::op_code_t op;
    calc_pkg::mat_t     exp_m;
    int                 id_a;
    int                 id_b;
    int                 wait_cyc;
    op   = op_from_sw(rows[n].sw);
    id_a = rows[n].dig_a - 8'h30;
    id_b = rows[n].dig_b - 8'h30;
    if (in_done_wait) press_button(1'b0);  // Back to SELECT_OP
    if (rows[n].mode == MODE_PROBE) begin
      set_switches(8'h00, rows[n].scalar);
      press_button(1'b0);  // No op bit so it must be ignored
    end
    set_switches(rows[n].sw, rows[n].scalar);
    press_button(1'b0);
    if (rows[n].mode == MODE_PROBE) begin
      send_byte("x");  // Not a digit
      send_byte(":");  // Just above '9'
    end
    send_byte(rows[n].dig_a);
    if (op == calc_pkg::OP_ADD || op == calc_pkg::OP_MAT_MUL) send_byte(rows[n].dig_b);
    if (op == calc_pkg::OP_SCALAR_MUL) press_button(1'b0);
    if (rows[n].is_err) begin
      while (!calc_err) @(negedge clk);
      if (rows[n].mode == MODE_ESC) begin
        @(negedge clk);
        btn_esc = 1'b1;
        @(negedge clk);
        check_val("calc_err", calc_err, 1'b0);  // Cleared on the escape edge
        btn_esc = 1'b0;
      end else begin
        wait_cyc = 0;
        while (calc_err && wait_cyc < ERR_HOLD_CYCLES + 2) begin
          @(negedge clk);
          wait_cyc++;
        end
        check_val("calc_err", calc_err, 1'b0);
      end
      repeat (4) @(negedge clk);
      check_val("tx_byte_count", rx_bytes.size(), 0);
      check_val("tx_valid", tx_valid, 1'b0);
      in_done_wait = 1'b0;
    end else begin
      exp_m = ref_result(op, mats[id_a], mats[id_b], rows[n].scalar);
      while (rx_bytes.size() < 4) @(negedge clk);
      repeat (8) @(negedge clk);  // Catch any extra byte
      check_val("tx_byte_count", rx_bytes.size(), 4);
      check_val("tx_valid", tx_valid, 1'b0);  // Printer idle after four bytes
      for (int k = 0; k < 4; k++) begin
        check_val($sformatf("tx_data[%0d]", k), rx_bytes[k], exp_m[8*k +: 8]);
      end
      check_val("calc_err", calc_err, 1'b0);
      in_done_wait = 1'b1;
    end
    rx_bytes.delete();
  endtask

  // Random tx_ready and capture of each accepted byte
  initial begin
    logic [31:0] rnd;
    logic        rdy;
    tx_ready = 1'b0;
    wait (loaded);
    forever begin
      @(negedge clk);
      rnd = $random(seed);
      rdy = rnd[0];
      if (tx_valid && rdy) rx_bytes.push_back(tx_data);  // Transfers on next rising edge
      tx_ready = rdy;
    end
  end

  always @(negedge clk) begin
    if (calc_sys_done) sys_done_cnt++;
  end

  // Bound assertion failures end the run at once
  always @(negedge clk) begin
    if (matrix_calc_top_inst.calc_checker_inst.fail_cnt != 0) begin
      $display("A bound assertion on the controller or printer failed");
      $display("=== FAIL ===");
      $fatal(1, "Assertion failure");
    end
  end

  initial begin
    repeat (NUM_ROWS * 400) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the calculator stopped responding",
             NUM_ROWS * 400);
    $display("=== FAIL ===");
    $fatal(1, "Simulation hang");
  end

  initial begin
    start_en    = 1'b0;
    sw_mode_sel = 8'h00;
    sw_scalar   = 8'h00;
    btn_confirm = 1'b0;
    btn_esc     = 1'b0;
    rx_data     = 8'h00;
    rx_done     = 1'b0;
    load_en     = 1'b0;
    load_id     = '0;
    load_data   = '0;
    //             sw     A    B    scalar is_err mode
    rows[0] = '{8'h08, "0", "0", 8'd0, 1'b0, MODE_PLAIN};  // Transpose A0
    rows[1] = '{8'h10, "0", "1", 8'd0, 1'b0, MODE_PLAIN};  // A0 + A1
    rows[2] = '{8'h20, "2", "0", 8'd3, 1'b0, MODE_PLAIN};  // 3 * A2
    rows[3] = '{8'h48, "1", "3", 8'd0, 1'b0, MODE_PLAIN};  // A1 x A3 with mul beating transpose
    rows[4] = '{8'h10, "7", "1", 8'd0, 1'b1, MODE_PLAIN};  // ID 7 missing
    rows[5] = '{8'h80, "0", "0", 8'd0, 1'b1, MODE_ESC};    // Conv unsupported
    rows[6] = '{8'h08, "3", "0", 8'd0, 1'b0, MODE_PROBE};  // Transpose A3
    wait (rst_n);
    check_val("tx_valid", tx_valid, 1'b0);  // Outputs low out of reset
    check_val("calc_err", calc_err, 1'b0);
    check_val("calc_sys_done", calc_sys_done, 1'b0);
    @(negedge clk);
    start_en = 1'b1;
    for (int i = 0; i < calc_pkg::NUM_MATS; i++) begin
      @(negedge clk);
      load_en   = 1'b1;
      load_id   = calc_pkg::mat_id_t'(i);
      load_data = $random(seed);
      mats[i]   = load_data;
    end
    @(negedge clk);
    load_en = 1'b0;
    loaded  = 1'b1;
    for (int n = 0; n < NUM_ROWS; n++) run_row(n);
    // Leave calculator mode from SELECT_OP
    press_button(1'b0);
    check_val("calc_sys_done_count", sys_done_cnt, 0);
    start_en = 1'b0;
    press_button(1'b1);
    repeat (4) @(negedge clk);
    check_val("calc_sys_done_count", sys_done_cnt, 1);
    if (matrix_calc_top_inst.calc_checker_inst.fail_cnt == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times",
               matrix_calc_top_inst.calc_checker_inst.fail_cnt);
      $display("=== FAIL ===");
      $fatal(1, "Assertion failure");
    end
  end

endmodule

// ==== compile.f ====
common/calc_pkg.sv
common/alu_if.sv
hdl/calc_ctrl.sv
hdl/mat_store.sv
alu/mat_alu.sv
hdl/result_printer.sv
hdl/matrix_calc_top.sv
test/tb_clock.sv
test/calc_checker.sv
test/tb_matrix_calc.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide by the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_matrix_calc \
  && ./obj_dir/Vtb_matrix_calc > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "=== PASS ===" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
